// ==== hdl/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Byte offset within a 32-byte line
`define ICACHE_OFFSET_BITS 5

// 16 sets
`define ICACHE_SET_BITS 4

// Remaining upper address bits
`define ICACHE_TAG_BITS 23

// Associativity
`define ICACHE_NUM_WAYS 4

// One memory beat fills a whole line
`define ICACHE_LINE_BITS 256

// Instruction words returned per fetch
`define ICACHE_FETCH_WORDS 2

`endif

// ==== hdl/icache_pkg.sv ====
`include "icache_macros.svh"

package icache_pkg;

    // Address split into line fields
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]    tag;
        logic [`ICACHE_SET_BITS-1:0]    set;
        logic [`ICACHE_OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  addr;
        addr_fields_t fields;
    } fetch_addr_u;

    // Fetch to process pipeline register
    typedef struct packed {
        logic                           read;
        logic [`ICACHE_TAG_BITS-1:0]    tag;
        logic [`ICACHE_SET_BITS-1:0]    set;
        logic [`ICACHE_OFFSET_BITS-1:0] offset;
    } stage_reg_t;

    // word0 sits in the low half
    typedef struct packed {
        logic [31:0] word1;
        logic [31:0] word0;
    } fetch_data_t;

    typedef struct packed {
        logic        read;
        logic [31:0] addr;
    } mem_req_t;

    typedef logic [$clog2(`ICACHE_NUM_WAYS)-1:0] way_t;

    // Tree bits with the root in bit 0
    typedef logic [`ICACHE_NUM_WAYS-2:0] plru_t;

endpackage

// ==== hdl/icache_sram.sv ====
`timescale 1ns/1ps

module icache_sram #(
    parameter int DEPTH_BITS = 4,
    parameter int WIDTH      = 32
) (
    input  logic                  clk,
    input  logic                  csb,
    input  logic                  web,
    input  logic [WIDTH/8-1:0]    wmask,
    input  logic [DEPTH_BITS-1:0] addr,
    input  logic [WIDTH-1:0]      din,
    output logic [WIDTH-1:0]      dout
);

    localparam int BYTES = WIDTH / 8;

    logic [WIDTH-1:0] mem [2**DEPTH_BITS];

    // Active low select and write enable
    always_ff @(posedge clk) begin
        if (!csb) begin
            if (!web) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (wmask[b]) begin
                        mem[addr][8*b +: 8] <= din[8*b +: 8];
                    end
                end
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

// ==== hdl/icache_flag_array.sv ====
`timescale 1ns/1ps

module icache_flag_array #(
    parameter int DEPTH_BITS = 4,
    parameter int WIDTH      = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_en,
    input  logic [DEPTH_BITS-1:0] rd_addr,
    input  logic                  wr_en,
    input  logic [DEPTH_BITS-1:0] wr_addr,
    input  logic [WIDTH-1:0]      wr_data,
    output logic [WIDTH-1:0]      rd_data
);

    logic [WIDTH-1:0] flags [2**DEPTH_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**DEPTH_BITS; i++) begin
                flags[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                flags[wr_addr] <= wr_data;
            end
            if (rd_en) begin
                // Same-set write lands in the read result
                if (wr_en && wr_addr == rd_addr) begin
                    rd_data <= wr_data;
                end else begin
                    rd_data <= flags[rd_addr];
                end
            end
        end
    end

endmodule

// ==== hdl/plru_update.sv ====
`timescale 1ns/1ps

module plru_update (
    input  icache_pkg::plru_t current_plru,
    input  icache_pkg::way_t  hit_way,
    output icache_pkg::plru_t next_plru,
    output icache_pkg::way_t  replace_way
);

    // Victim walk goes left on a root of 0
    always_comb begin
        if (!current_plru[0]) begin
            if (current_plru[1]) begin
                replace_way = icache_pkg::way_t'(1);
            end else begin
                replace_way = icache_pkg::way_t'(0);
            end
        end else begin
            if (current_plru[2]) begin
                replace_way = icache_pkg::way_t'(3);
            end else begin
                replace_way = icache_pkg::way_t'(2);
            end
        end
    end

    // Point the path away from the touched way
    always_comb begin
        next_plru    = current_plru;
        next_plru[0] = ~hit_way[1];
        if (!hit_way[1]) begin
            next_plru[1] = ~hit_way[0];
        end else begin
            next_plru[2] = ~hit_way[0];
        end
    end

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        kill,
    input  icache_pkg::stage_reg_t      stage,
    input  logic [`ICACHE_TAG_BITS-1:0] tag_out [`ICACHE_NUM_WAYS],
    input  logic [`ICACHE_NUM_WAYS-1:0] valid_out,
    input  logic                        mem_ready,
    input  logic                        mem_rvalid,
    output logic                        stall,
    output logic                        fill_done,
    output icache_pkg::way_t            hit_way,
    output icache_pkg::mem_req_t        mem_req
);

    typedef enum logic [1:0] {
        s_idle,
        s_request,
        s_wait
    } state_t;

    state_t                  state;
    state_t                  state_next;
    logic                    hit;
    logic                    miss;
    logic                    start;
    logic                    refill;
    logic                    drain;
    logic [31:0]             req_addr;
    icache_pkg::fetch_addr_u line_addr;

    // ==============================
    // Tag compare
    // ==============================
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < `ICACHE_NUM_WAYS; i++) begin
            if (valid_out[i] && tag_out[i] == stage.tag) begin
                hit     = 1'b1;
                hit_way = icache_pkg::way_t'(i);
            end
        end
    end

    assign miss = stage.read && !hit;

    // Refill cycle rereads the arrays, so no new miss is started there
    assign start     = (state == s_idle) && !refill && miss && !kill;
    assign fill_done = (state == s_wait) && mem_rvalid && !drain && !kill;
    assign stall     = (state != s_idle) || refill || miss;

    // ==============================
    // Line fill sequencing
    // ==============================
    always_comb begin
        line_addr.fields.tag    = stage.tag;
        line_addr.fields.set    = stage.set;
        line_addr.fields.offset = '0;
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle:    if (start) state_next = s_request;
            s_request: if (mem_ready) state_next = s_wait;
            s_wait:    if (mem_rvalid) state_next = s_idle;
            default:   state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= s_idle;
            refill <= 1'b0;
            drain  <= 1'b0;
        end else begin
            state  <= state_next;
            refill <= fill_done;
            if (mem_rvalid) begin
                drain <= 1'b0;
            end else if (kill && state != s_idle) begin
                drain <= 1'b1;
            end
        end
    end

    // Address stays fixed even if kill reloads the stage
    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= line_addr.addr;
        end
    end

    assign mem_req.read = (state == s_request);
    assign mem_req.addr = req_addr;

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [31:0]                  ufp_addr,
    input  logic                         ufp_read,
    output icache_pkg::fetch_data_t      ufp_rdata,
    output logic                         ufp_resp,
    input  logic                         kill,
    output icache_pkg::mem_req_t         mem_req,
    input  logic                         mem_ready,
    input  logic [`ICACHE_LINE_BITS-1:0] mem_rdata,
    input  logic                         mem_rvalid
);

    localparam int WAYS  = `ICACHE_NUM_WAYS;
    localparam int TAG_W = `ICACHE_TAG_BITS + 1;

    icache_pkg::fetch_addr_u      in_addr;
    icache_pkg::stage_reg_t       stage;
    icache_pkg::way_t             hit_way;
    icache_pkg::way_t             replace_way;
    icache_pkg::plru_t            plru_out;
    icache_pkg::plru_t            plru_next;
    logic                         stall;
    logic                         fill_done;
    logic                         refill;
    logic                         accept;
    logic                         array_rd;
    logic [`ICACHE_SET_BITS-1:0]  array_set;
    logic [WAYS-1:0]              fill_way;
    logic [WAYS-1:0]              way_csb;
    logic [WAYS-1:0]              way_web;
    logic [WAYS-1:0]              valid_out;
    logic [`ICACHE_LINE_BITS-1:0] data_out [WAYS];
    logic [TAG_W-1:0]             tag_out [WAYS];
    logic [`ICACHE_TAG_BITS-1:0]  tag_cmp [WAYS];
    logic [`ICACHE_FETCH_WORDS*32-1:0] fetch_bits;

    // ==============================
    // Fetch stage
    // ==============================
    assign in_addr.addr = ufp_addr;
    assign accept       = !stall || kill;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.read <= 1'b0;
        end else if (accept) begin
            stage.read   <= ufp_read;
            stage.tag    <= in_addr.fields.tag;
            stage.set    <= in_addr.fields.set;
            stage.offset <= in_addr.fields.offset;
        end
    end

    // Cycle after a fill rereads the stage set
    always_ff @(posedge clk) begin
        if (rst) begin
            refill <= 1'b0;
        end else begin
            refill <= fill_done;
        end
    end

    assign array_rd  = accept || refill;
    assign array_set = accept ? in_addr.fields.set : stage.set;
    assign fill_way  = fill_done ? (WAYS'(1) << replace_way) : '0;
    assign way_csb   = ~({WAYS{array_rd}} | fill_way);
    assign way_web   = ~fill_way;

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        icache_sram #(
            .DEPTH_BITS (`ICACHE_SET_BITS),
            .WIDTH      (`ICACHE_LINE_BITS)
        ) data_array (
            .clk   (clk),
            .csb   (way_csb[i]),
            .web   (way_web[i]),
            .wmask ('1),
            .addr  (array_set),
            .din   (mem_rdata),
            .dout  (data_out[i])
        );

        // Tag padded to a whole byte
        icache_sram #(
            .DEPTH_BITS (`ICACHE_SET_BITS),
            .WIDTH      (TAG_W)
        ) tag_array (
            .clk   (clk),
            .csb   (way_csb[i]),
            .web   (way_web[i]),
            .wmask ('1),
            .addr  (array_set),
            .din   ({1'b0, stage.tag}),
            .dout  (tag_out[i])
        );

        icache_flag_array #(
            .DEPTH_BITS (`ICACHE_SET_BITS),
            .WIDTH      (1)
        ) valid_array (
            .clk     (clk),
            .rst     (rst),
            .rd_en   (array_rd),
            .rd_addr (array_set),
            .wr_en   (fill_way[i]),
            .wr_addr (stage.set),
            .wr_data (1'b1),
            .rd_data (valid_out[i])
        );

        assign tag_cmp[i] = tag_out[i][`ICACHE_TAG_BITS-1:0];
    end

    // PLRU written back on every response
    icache_flag_array #(
        .DEPTH_BITS (`ICACHE_SET_BITS),
        .WIDTH      (WAYS - 1)
    ) plru_array (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (array_rd),
        .rd_addr (array_set),
        .wr_en   (ufp_resp),
        .wr_addr (stage.set),
        .wr_data (plru_next),
        .rd_data (plru_out)
    );

    // ==============================
    // Process stage
    // ==============================
    icache_ctrl icache_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .kill       (kill),
        .stage      (stage),
        .tag_out    (tag_cmp),
        .valid_out  (valid_out),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_rvalid),
        .stall      (stall),
        .fill_done  (fill_done),
        .hit_way    (hit_way),
        .mem_req    (mem_req)
    );

    plru_update plru_update_i (
        .current_plru (plru_out),
        .hit_way      (hit_way),
        .next_plru    (plru_next),
        .replace_way  (replace_way)
    );

    // Consecutive words starting at the word offset
    always_comb begin
        int unsigned base;
        base = 32'(stage.offset[`ICACHE_OFFSET_BITS-1:2]);
        for (int k = 0; k < `ICACHE_FETCH_WORDS; k++) begin
            fetch_bits[32*k +: 32] = data_out[hit_way][32*(base + k) +: 32];
        end
    end

    assign ufp_rdata = icache_pkg::fetch_data_t'(fetch_bits);
    assign ufp_resp  = stage.read && !stall && !kill;

endmodule

// ==== bench/icache_mem_model.sv ====
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_mem_model (
    input  logic                         clk,
    input  logic                         rst,
    input  icache_pkg::mem_req_t         mem_req,
    output logic                         mem_ready,
    output logic [`ICACHE_LINE_BITS-1:0] mem_rdata,
    output logic                         mem_rvalid,
    output int unsigned                  reads
);

    localparam int MAX_DELAY = 8;

    // Byte value stored at any memory address
    function automatic logic [7:0] pattern_byte(input logic [31:0] a);
        return a[7:0] + 8'd3 * a[15:8] + 8'd5 * a[23:16] + 8'd7 * a[31:24];
    endfunction

    task automatic serve_line();
        logic [31:0]                  base;
        logic [`ICACHE_LINE_BITS-1:0] line;
        int unsigned                  delay;
        delay = $urandom_range(MAX_DELAY, 1);
        repeat (delay) @(negedge clk);
        base      = mem_req.addr;
        mem_ready = 1'b1;
        @(negedge clk);
        mem_ready = 1'b0;
        for (int i = 0; i < `ICACHE_LINE_BITS / 8; i++) begin
            line[8*i +: 8] = pattern_byte(base + i);
        end
        // Acceptance edge already counts as one cycle
        delay = $urandom_range(MAX_DELAY, 1);
        repeat (delay - 1) @(negedge clk);
        mem_rdata  = line;
        mem_rvalid = 1'b1;
        reads++;
        @(negedge clk);
        mem_rvalid = 1'b0;
    endtask

    initial begin
        mem_ready  = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        reads      = 0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req.read) begin
                serve_line();
            end
        end
    end

endmodule

// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 5;
    localparam int SETS           = 2**`ICACHE_SET_BITS;
    localparam int WAYS           = `ICACHE_NUM_WAYS;
    localparam int MAX_WORD       = 6;
    localparam int RANDOM_REQS    = 200;
    localparam int NUM_REQUESTS   = 1 + (MAX_WORD + 1) + 10 + RANDOM_REQS + 3 + 2;
    localparam int CYCLES_PER_REQ = 40;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * CYCLES_PER_REQ + 2 * RESET_CYCLES;

    logic                         clk;
    logic                         rst;
    logic [31:0]                  ufp_addr;
    logic                         ufp_read;
    logic                         kill;
    icache_pkg::fetch_data_t      ufp_rdata;
    logic                         ufp_resp;
    icache_pkg::mem_req_t         mem_req;
    logic                         mem_ready;
    logic [`ICACHE_LINE_BITS-1:0] mem_rdata;
    logic                         mem_rvalid;
    int unsigned                  mem_reads;

    logic [31:0]                 expected_q [$];
    logic                        busy;
    int unsigned                 cycle;
    int unsigned                 checks;
    int unsigned                 errors;
    int unsigned                 test_num;
    int unsigned                 test_checks;
    int unsigned                 test_errors;
    int unsigned                 start_cycle;
    int unsigned                 reads_before;
    int unsigned                 model_reads;
    int unsigned                 extra_reads;
    logic [`ICACHE_TAG_BITS-1:0] model_tag [SETS][WAYS];
    logic [WAYS-1:0]             model_valid [SETS];
    icache_pkg::plru_t           model_plru [SETS];

    icache icache_i (
        .clk        (clk),
        .rst        (rst),
        .ufp_addr   (ufp_addr),
        .ufp_read   (ufp_read),
        .ufp_rdata  (ufp_rdata),
        .ufp_resp   (ufp_resp),
        .kill       (kill),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid)
    );

    icache_mem_model mem_model_i (
        .clk        (clk),
        .rst        (rst),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid),
        .reads      (mem_reads)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic logic [7:0] pattern_byte(input logic [31:0] a);
        return a[7:0] + 8'd3 * a[15:8] + 8'd5 * a[23:16] + 8'd7 * a[31:24];
    endfunction

    // Little endian words at addr and addr + 4
    function automatic icache_pkg::fetch_data_t expected_fetch(input logic [31:0] addr);
        icache_pkg::fetch_data_t f;
        for (int i = 0; i < 4; i++) begin
            f.word0[8*i +: 8] = pattern_byte(addr + i);
            f.word1[8*i +: 8] = pattern_byte(addr + 4 + i);
        end
        return f;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return (tag << (`ICACHE_SET_BITS + `ICACHE_OFFSET_BITS))
            | (set << `ICACHE_OFFSET_BITS) | (word << 2);
    endfunction

    // Root 0 sends the victim search left
    function automatic int victim(input icache_pkg::plru_t p);
        if (!p[0]) begin
            return p[1] ? 1 : 0;
        end
        return p[2] ? 3 : 2;
    endfunction

    function automatic icache_pkg::plru_t touch(input icache_pkg::plru_t p, input int way);
        icache_pkg::plru_t n;
        n    = p;
        n[0] = (way < 2);
        if (way < 2) begin
            n[1] = (way == 0);
        end else begin
            n[2] = (way == 2);
        end
        return n;
    endfunction

    task automatic model_access(input logic [31:0] addr);
        logic [`ICACHE_SET_BITS-1:0] set;
        logic [`ICACHE_TAG_BITS-1:0] tag;
        int                          way;
        set = addr[`ICACHE_SET_BITS+`ICACHE_OFFSET_BITS-1:`ICACHE_OFFSET_BITS];
        tag = addr[31:`ICACHE_SET_BITS+`ICACHE_OFFSET_BITS];
        way = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == tag) begin
                way = w;
            end
        end
        if (way < 0) begin
            way                   = victim(model_plru[set]);
            model_valid[set][way] = 1'b1;
            model_tag[set][way]   = tag;
            model_reads++;
        end
        model_plru[set] = touch(model_plru[set], way);
    endtask

    task automatic model_reset();
        for (int s = 0; s < SETS; s++) begin
            model_valid[s] = '0;
            model_plru[s]  = '0;
        end
    endtask

    // ==============================
    // Response checking
    // ==============================
    task automatic check_reads();
        checks++;
        assert (mem_reads == model_reads + extra_reads) else begin
            $display("FAIL mem_reads: got %h, expected %h", mem_reads, model_reads + extra_reads);
            errors++;
        end
    endtask

    task automatic check_response();
        logic [31:0]             addr;
        icache_pkg::fetch_data_t want;
        assert (expected_q.size() != 0) else begin
            $display("Response arrived with no request outstanding");
            errors++;
        end
        if (expected_q.size() != 0) begin
            addr = expected_q.pop_front();
            want = expected_fetch(addr);
            model_access(addr);
            checks++;
            assert (ufp_rdata.word0 == want.word0) else begin
                $display("FAIL ufp_rdata.word0 at %h: got %h, expected %h",
                         addr, ufp_rdata.word0, want.word0);
                errors++;
            end
            assert (ufp_rdata.word1 == want.word1) else begin
                $display("FAIL ufp_rdata.word1 at %h: got %h, expected %h",
                         addr, ufp_rdata.word1, want.word1);
                errors++;
            end
            check_reads();
        end
    endtask

    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle++;
            if (!rst && ufp_resp) begin
                check_response();
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    // Held inputs are taken on the edge that ends a response cycle
    task automatic issue(input logic [31:0] addr);
        while (busy && !ufp_resp) @(negedge clk);
        ufp_read = 1'b1;
        ufp_addr = addr;
        expected_q.push_back(addr);
        busy = 1'b1;
        @(negedge clk);
    endtask

    task automatic settle();
        while (busy && !ufp_resp) @(negedge clk);
        ufp_read = 1'b0;
        busy     = 1'b0;
        @(negedge clk);
    endtask

    task automatic kill_pending(input logic [31:0] miss_addr, input logic [31:0] next_addr);
        issue(miss_addr);
        while (!mem_req.read) @(negedge clk);
        kill     = 1'b1;
        ufp_addr = next_addr;
        void'(expected_q.pop_back());
        expected_q.push_back(next_addr);
        // Drained line is still read from memory
        extra_reads++;
        @(negedge clk);
        kill = 1'b0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        model_reset();
    endtask

    task automatic end_test(input string name);
        settle();
        check_reads();
        $display("test %0d (%s): %0d checks, %0d errors",
                 test_num, name, checks - test_checks, errors - test_errors);
        test_num++;
        test_checks = checks;
        test_errors = errors;
    endtask

    initial begin
        void'($urandom(32'hd584_24bc));
        rst         = 1'b1;
        ufp_addr    = '0;
        ufp_read    = 1'b0;
        kill        = 1'b0;
        busy        = 1'b0;
        checks      = 0;
        errors      = 0;
        test_num    = 1;
        test_checks = 0;
        test_errors = 0;
        model_reads = 0;
        extra_reads = 0;
        apply_reset();

        issue(make_addr(8, 0, 2));
        end_test("cold miss");

        start_cycle = cycle;
        for (int w = 0; w <= MAX_WORD; w++) begin
            issue(make_addr(8, 0, w));
        end
        settle();
        checks++;
        assert (cycle - start_cycle == MAX_WORD + 2) else begin
            $display("Hits were not answered back to back: %0d cycles for %0d requests",
                     cycle - start_cycle, MAX_WORD + 1);
            errors++;
        end
        end_test("repeated hits");

        // Set 5 is untouched since reset, so fills land in ways 0, 2, 1, 3
        issue(make_addr(256, 5, 1));
        issue(make_addr(257, 5, 3));
        issue(make_addr(258, 5, 5));
        issue(make_addr(259, 5, 0));
        issue(make_addr(256, 5, 2));
        issue(make_addr(260, 5, 6));
        issue(make_addr(256, 5, 0));
        issue(make_addr(258, 5, 1));
        issue(make_addr(259, 5, 2));
        issue(make_addr(257, 5, 4));
        end_test("replacement");

        for (int n = 0; n < RANDOM_REQS; n++) begin
            issue(make_addr(64 + $urandom_range(5, 0), $urandom_range(3, 0),
                            $urandom_range(MAX_WORD, 0)));
        end
        end_test("random stream");

        kill_pending(make_addr(768, 2, 2), make_addr(769, 2, 4));
        issue(make_addr(768, 2, 2));
        end_test("kill");

        reads_before = mem_reads;
        apply_reset();
        issue(make_addr(8, 0, 2));
        issue(make_addr(8, 0, 3));
        settle();
        checks++;
        assert (mem_reads == reads_before + 1) else begin
            $display("FAIL mem_reads after reset: got %h, expected %h",
                     mem_reads, reads_before + 1);
            errors++;
        end
        end_test("second reset");

        $display("tests %0d, checks %0d, errors %0d", test_num - 1, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_sram.sv
hdl/icache_flag_array.sv
hdl/plru_update.sv
hdl/icache_ctrl.sv
hdl/icache.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module icache_tb -o icache_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/icache_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
exit 1
